//--- build.f
ooo_pkg.sv
ooo_ifs.sv
rename_table.sv
exec_unit.sv
reorder_buffer.sv
dispatch_stage.sv
ooo_top.sv
ooo_sva.sv
ooo_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = ooo_tb
FILELIST  = build.f
SIM       = obj_dir/V$(TOP)
SOURCES   = $(shell cat $(FILELIST))
RUN_ARGS  = +verilator+error+limit+100
LOG       = sim.log
FAIL_MSG  = FAIL: see errors above

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	./$(SIM) $(RUN_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG) || [ $$status -ne 0 ]; then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

//--- ooo_tb.sv
`timescale 1ns/1ns
`default_nettype none

module ooo_tb
    import ooo_pkg::*;
();

    localparam int ROB_DEPTH  = 8;
    localparam int NUM_RANDOM = 60;

    typedef struct packed {
        logic [2:0] grp;
        op_t        op;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        data_t      imm;
        logic       use_imm;
        logic [3:0] gap;
    } row_t;

    typedef struct packed {
        logic [2:0] grp;
        reg_idx_t   rd;
        data_t      value;
    } expect_t;

    logic     clk;
    logic     rst_n;
    logic     in_valid;
    op_t      in_op;
    reg_idx_t in_rd;
    reg_idx_t in_rs1;
    reg_idx_t in_rs2;
    data_t    in_imm;
    logic     in_use_imm;
    logic     stall;
    logic     commit_valid;
    reg_idx_t commit_rd;
    tag_t     commit_tag;
    data_t    commit_value;

    row_t     rows_q [$];
    expect_t  expect_q [$];
    data_t    gold_regs [NUM_REGS];
    tag_t     next_tag;
    int       commit_count;
    int       seed;
    logic     table_built;

    ooo_top dut (
        .clk, .rst_n,
        .in_valid, .in_op, .in_rd, .in_rs1, .in_rs2, .in_imm, .in_use_imm,
        .stall,
        .commit_valid, .commit_rd, .commit_tag, .commit_value
    );

    bind ooo_top ooo_sva #(.DEPTH(ROB_DEPTH)) u_sva (
        .clk, .rst_n, .in_valid, .stall, .alloc, .commit_valid, .commit_tag,
        .fast_valid (fast_res.valid),
        .fast_tag   (fast_res.tag),
        .slow_valid (slow_res.valid),
        .slow_tag   (slow_res.tag)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic string grp_name(input logic [2:0] grp);
        case (grp)
            3'd0:    return "imm_load";
            3'd1:    return "r0_write";
            3'd2:    return "out_of_order";
            3'd3:    return "dep_chain";
            3'd4:    return "back_to_back";
            default: return "random";
        endcase
    endfunction

    function automatic data_t golden_op(input op_t op, input data_t a, input data_t b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_XOR:  return a ^ b;
            default: return a * b;
        endcase
    endfunction

    task automatic stop_with_failure();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            $display("ERROR %s: value expected %h, actual %h", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t exp, input reg_idx_t act);
        if (act !== exp) begin
            $display("ERROR %s: rd expected %0d, actual %0d", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_tag(input string name, input tag_t exp, input tag_t act);
        if (act !== exp) begin
            $display("ERROR %s: tag expected %0d, actual %0d", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %s: flag expected %0b, actual %0b", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic add_row(input int grp, input op_t op, input int rd, input int rs1,
                           input int rs2, input int imm, input int use_imm, input int gap);
        row_t r;
        r.grp     = 3'(grp);
        r.op      = op;
        r.rd      = reg_idx_t'(rd);
        r.rs1     = reg_idx_t'(rs1);
        r.rs2     = reg_idx_t'(rs2);
        r.imm     = data_t'(imm);
        r.use_imm = 1'(use_imm);
        r.gap     = 4'(gap);
        rows_q.push_back(r);
    endtask

    task automatic build_table();
        int   r;
        int   gap;
        op_t  op;
        logic prev_slow;
        for (int i = 1; i < 8; i++) begin
            add_row(0, OP_ADD, i, 0, 0, 32'h1000 + i * 32'h111, 1, i % 2);
        end
        // r0 commits its value but keeps reading zero
        add_row(1, OP_ADD, 0, 0, 0, 32'h55, 1, 0);
        add_row(1, OP_ADD, 8, 0, 0, 0, 0, 0);
        add_row(1, OP_XOR, 9, 0, 0, 32'h3c, 1, 1);
        // slow mul ahead of fast independent ops
        add_row(2, OP_MUL, 10, 1, 2, 0, 0, 0);
        add_row(2, OP_ADD, 11, 3, 0, 5, 1, 0);
        add_row(2, OP_SUB, 12, 4, 5, 0, 0, 0);
        add_row(2, OP_XOR, 13, 6, 7, 0, 0, 0);
        add_row(2, OP_MUL, 14, 10, 3, 0, 0, 0);
        add_row(2, OP_AND, 15, 1, 2, 0, 0, 2);
        add_row(3, OP_ADD, 7, 7, 0, 1, 1, 0);
        add_row(3, OP_MUL, 7, 7, 7, 0, 0, 0);
        add_row(3, OP_SUB, 7, 7, 1, 0, 0, 0);
        add_row(3, OP_ADD, 8, 7, 7, 0, 0, 2);
        add_row(3, OP_MUL, 9, 8, 7, 0, 0, 0);
        add_row(3, OP_XOR, 9, 9, 8, 0, 0, 0);
        add_row(3, OP_AND, 10, 9, 0, 32'hffff, 1, 3);
        // more rows than rob entries, no gaps
        for (int i = 0; i < 12; i++) begin
            op = (i % 3 == 0) ? OP_MUL : OP_ADD;
            add_row(4, op, 1 + i % 6, 1 + i % 6, 1 + (i + 1) % 6, 0, 0, 0);
        end
        prev_slow = 1'b0;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            r   = $random(seed);
            op  = op_t'(r[2:0] % 3'd5);
            // keep fast ops right behind a mul so they overtake it
            gap = prev_slow ? 0 : int'(r[25:24]);
            prev_slow = is_slow_op(op);
            add_row(5, op, int'(r[6:3]), int'(r[10:7]), int'(r[14:11]), $random(seed),
                    int'(r[15]), gap);
        end
    endtask

    task automatic apply_row(input row_t row);
        data_t   a;
        data_t   b;
        expect_t e;
        in_valid = 1'b0;
        repeat (row.gap) begin
            @(posedge clk);
            #1;
        end
        while (stall) begin
            @(posedge clk);
            #1;
        end
        in_op      = row.op;
        in_rd      = row.rd;
        in_rs1     = row.rs1;
        in_rs2     = row.rs2;
        in_imm     = row.imm;
        in_use_imm = row.use_imm;
        in_valid   = 1'b1;
        // stall is low, so this edge accepts the row in program order
        a       = gold_regs[row.rs1];
        b       = row.use_imm ? row.imm : gold_regs[row.rs2];
        e.grp   = row.grp;
        e.rd    = row.rd;
        e.value = golden_op(row.op, a, b);
        if (row.rd != '0) begin
            gold_regs[row.rd] = e.value;
        end
        expect_q.push_back(e);
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    always @(negedge clk) begin
        expect_t e;
        if (rst_n && commit_valid) begin
            if (expect_q.size() == 0) begin
                $display("a commit appeared with no accepted instruction outstanding");
                stop_with_failure();
            end else begin
                e = expect_q.pop_front();
                check_reg(grp_name(e.grp), e.rd, commit_rd);
                check_value(grp_name(e.grp), e.value, commit_value);
                check_tag(grp_name(e.grp), next_tag, commit_tag);
                next_tag = (next_tag == tag_t'(ROB_DEPTH)) ? tag_t'(1) : next_tag + tag_t'(1);
                commit_count++;
            end
        end
    end

    initial begin
        wait (table_built);
        repeat (40 * rows_q.size() + 100) @(posedge clk);
        $display("timeout: the core stopped before all instructions committed");
        stop_with_failure();
    end

    initial begin
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_op        = OP_ADD;
        in_rd        = '0;
        in_rs1       = '0;
        in_rs2       = '0;
        in_imm       = '0;
        in_use_imm   = 1'b0;
        seed         = 55;
        next_tag     = tag_t'(1);
        commit_count = 0;
        table_built  = 1'b0;
        for (int i = 0; i < NUM_REGS; i++) begin
            gold_regs[i] = '0;
        end
        build_table();
        table_built = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // empty core right out of reset
        check_flag("reset_stall", 1'b0, stall);
        check_flag("reset_commit", 1'b0, commit_valid);
        foreach (rows_q[i]) begin
            apply_row(rows_q[i]);
        end
        wait (commit_count == rows_q.size());
        // room for a stray extra commit to show up
        repeat (20) @(posedge clk);
        if (commit_count == rows_q.size() && expect_q.size() == 0 &&
            dut.u_sva.failures == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("commit count %0d against %0d rows, or a rob assertion fired",
                     commit_count, rows_q.size());
            stop_with_failure();
        end
    end

endmodule

`default_nettype wire

//--- ooo_sva.sv
`timescale 1ns/1ns
`default_nettype none

module ooo_sva
    import ooo_pkg::*;
#(
    parameter int DEPTH = 8
) (
    input logic clk,
    input logic rst_n,
    input logic in_valid,
    input logic stall,
    input logic alloc,
    input logic commit_valid,
    input tag_t commit_tag,
    input logic fast_valid,
    input tag_t fast_tag,
    input logic slow_valid,
    input tag_t slow_tag
);

    int   failures = 0;
    int   occupancy;
    tag_t next_tag;

    // entries allocated and not yet seen on the commit port
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            occupancy <= 0;
            next_tag  <= tag_t'(1);
        end else begin
            occupancy <= occupancy + int'(alloc) - int'(commit_valid);
            if (commit_valid) begin
                next_tag <= (commit_tag == tag_t'(DEPTH)) ? tag_t'(1) : commit_tag + tag_t'(1);
            end
        end
    end

    a_no_strobe_in_stall: assert property (@(posedge clk) disable iff (!rst_n)
        stall |-> !in_valid)
        else begin
            $error("input strobe while stall is high");
            failures++;
        end

    a_no_commit_empty: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid |-> occupancy > 0)
        else begin
            $error("commit from an empty reorder buffer");
            failures++;
        end

    a_tag_order: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid |-> commit_tag == next_tag)
        else begin
            $error("commit tag out of sequence");
            failures++;
        end

    a_result_tag: assert property (@(posedge clk) disable iff (!rst_n)
        (fast_valid |-> fast_tag != NO_TAG) and (slow_valid |-> slow_tag != NO_TAG))
        else begin
            $error("result strobe with tag zero");
            failures++;
        end

endmodule

`default_nettype wire

//--- ooo_top.sv
`timescale 1ns/1ns
`default_nettype none

module ooo_top
    import ooo_pkg::*;
#(
    parameter int ROB_DEPTH    = 8,
    parameter int FAST_LATENCY = 1,
    parameter int SLOW_LATENCY = 3
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  op_t      in_op,
    input  reg_idx_t in_rd,
    input  reg_idx_t in_rs1,
    input  reg_idx_t in_rs2,
    input  data_t    in_imm,
    input  logic     in_use_imm,
    output logic     stall,
    output logic     commit_valid,
    output reg_idx_t commit_rd,
    output tag_t     commit_tag,
    output data_t    commit_value
);

    reg_idx_t ren_rs1;
    reg_idx_t ren_rs2;
    data_t    ren_rs1_value;
    data_t    ren_rs2_value;
    tag_t     ren_rs1_tag;
    tag_t     ren_rs2_tag;
    logic     alloc;
    reg_idx_t alloc_rd;
    tag_t     alloc_tag;
    logic     rob_full;
    tag_t     lookup1_tag;
    tag_t     lookup2_tag;
    logic     lookup1_ready;
    data_t    lookup1_value;
    logic     lookup2_ready;
    data_t    lookup2_value;

    issue_if  fast_iss ();
    issue_if  slow_iss ();
    result_if fast_res ();
    result_if slow_res ();
    commit_if cmt ();

    dispatch_stage u_dispatch (
        .clk, .rst_n,
        .in_valid, .in_op, .in_rd, .in_rs1, .in_rs2, .in_imm, .in_use_imm,
        .stall,
        .ren_rs1, .ren_rs2, .ren_rs1_value, .ren_rs2_value, .ren_rs1_tag, .ren_rs2_tag,
        .alloc, .alloc_rd, .alloc_tag,
        .rob_full,
        .rob_lookup1_tag   (lookup1_tag),
        .rob_lookup2_tag   (lookup2_tag),
        .rob_lookup1_ready (lookup1_ready),
        .rob_lookup1_value (lookup1_value),
        .rob_lookup2_ready (lookup2_ready),
        .rob_lookup2_value (lookup2_value),
        .fast_iss, .slow_iss,
        .fast_snp (fast_res),
        .slow_snp (slow_res)
    );

    rename_table u_rename (
        .clk, .rst_n,
        .rs1 (ren_rs1), .rs2 (ren_rs2),
        .rs1_value (ren_rs1_value), .rs2_value (ren_rs2_value),
        .rs1_tag (ren_rs1_tag), .rs2_tag (ren_rs2_tag),
        .alloc, .alloc_rd, .alloc_tag,
        .cmt
    );

    reorder_buffer #(.DEPTH(ROB_DEPTH)) u_rob (
        .clk, .rst_n,
        .alloc, .alloc_rd, .alloc_tag,
        .full (rob_full),
        .lookup1_tag, .lookup2_tag,
        .lookup1_ready, .lookup1_value, .lookup2_ready, .lookup2_value,
        .fast_res, .slow_res,
        .cmt
    );

    exec_unit #(.LATENCY(FAST_LATENCY)) u_fast (
        .clk, .rst_n, .iss (fast_iss), .res (fast_res)
    );

    exec_unit #(.LATENCY(SLOW_LATENCY)) u_slow (
        .clk, .rst_n, .iss (slow_iss), .res (slow_res)
    );

    assign commit_valid = cmt.valid;
    assign commit_rd    = cmt.rd;
    assign commit_tag   = cmt.tag;
    assign commit_value = cmt.value;

endmodule

`default_nettype wire

//--- dispatch_stage.sv
`timescale 1ns/1ns
`default_nettype none

module dispatch_stage
    import ooo_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  op_t      in_op,
    input  reg_idx_t in_rd,
    input  reg_idx_t in_rs1,
    input  reg_idx_t in_rs2,
    input  data_t    in_imm,
    input  logic     in_use_imm,
    output logic     stall,
    output reg_idx_t ren_rs1,
    output reg_idx_t ren_rs2,
    input  data_t    ren_rs1_value,
    input  data_t    ren_rs2_value,
    input  tag_t     ren_rs1_tag,
    input  tag_t     ren_rs2_tag,
    output logic     alloc,
    output reg_idx_t alloc_rd,
    input  tag_t     alloc_tag,
    input  logic     rob_full,
    output tag_t     rob_lookup1_tag,
    output tag_t     rob_lookup2_tag,
    input  logic     rob_lookup1_ready,
    input  data_t    rob_lookup1_value,
    input  logic     rob_lookup2_ready,
    input  data_t    rob_lookup2_value,
    issue_if.src     fast_iss,
    issue_if.src     slow_iss,
    result_if.snoop  fast_snp,
    result_if.snoop  slow_snp
);

    typedef struct packed {
        logic  ok;
        data_t val;
    } opnd_t;

    typedef struct packed {
        logic  vld;
        tag_t  tag;
        data_t res;
    } bus_t;

    bus_t  fbus;
    bus_t  sbus;
    opnd_t new_a;
    opnd_t new_b;
    opnd_t hold_a;
    opnd_t hold_b;
    opnd_t hold_a_now;
    opnd_t hold_b_now;
    logic  accept;
    logic  go_new;
    logic  go_hold;
    logic  hold_valid;
    op_t   hold_op;
    tag_t  hold_tag;
    tag_t  hold_a_tag;
    tag_t  hold_b_tag;
    logic  iss_fast_q;
    logic  iss_slow_q;
    op_t   iss_op;
    data_t iss_a;
    data_t iss_b;
    tag_t  iss_tag;

    function automatic opnd_t snoop(input opnd_t cur, input tag_t t,
                                    input bus_t fb, input bus_t sb);
        opnd_t r;
        r = cur;
        if (!cur.ok && fb.vld && fb.tag == t) begin
            r.ok  = 1'b1;
            r.val = fb.res;
        end else if (!cur.ok && sb.vld && sb.tag == t) begin
            r.ok  = 1'b1;
            r.val = sb.res;
        end
        return r;
    endfunction

    // register file, then finished rob entry, then this cycle's buses
    function automatic opnd_t resolve(input tag_t t, input data_t rv, input logic lk_rdy,
                                      input data_t lk_val, input bus_t fb, input bus_t sb);
        opnd_t r;
        r.ok  = (t == NO_TAG) || lk_rdy;
        r.val = (t == NO_TAG) ? rv : lk_val;
        return snoop(r, t, fb, sb);
    endfunction

    assign fbus = {fast_snp.valid, fast_snp.tag, fast_snp.result};
    assign sbus = {slow_snp.valid, slow_snp.tag, slow_snp.result};

    assign ren_rs1         = in_rs1;
    assign ren_rs2         = in_rs2;
    assign rob_lookup1_tag = ren_rs1_tag;
    assign rob_lookup2_tag = ren_rs2_tag;

    assign stall    = rob_full || hold_valid;
    assign accept   = in_valid && !stall;
    assign alloc    = accept;
    assign alloc_rd = in_rd;

    always_comb begin
        new_a = resolve(ren_rs1_tag, ren_rs1_value, rob_lookup1_ready, rob_lookup1_value,
                        fbus, sbus);
        if (in_use_imm) begin
            new_b.ok  = 1'b1;
            new_b.val = in_imm;
        end else begin
            new_b = resolve(ren_rs2_tag, ren_rs2_value, rob_lookup2_ready, rob_lookup2_value,
                            fbus, sbus);
        end
        hold_a_now = snoop(hold_a, hold_a_tag, fbus, sbus);
        hold_b_now = snoop(hold_b, hold_b_tag, fbus, sbus);
    end

    assign go_new  = accept && new_a.ok && new_b.ok;
    assign go_hold = hold_valid && hold_a_now.ok && hold_b_now.ok;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_valid <= 1'b0;
            iss_fast_q <= 1'b0;
            iss_slow_q <= 1'b0;
        end else begin
            iss_fast_q <= (go_new && !is_slow_op(in_op)) || (go_hold && !is_slow_op(hold_op));
            iss_slow_q <= (go_new && is_slow_op(in_op)) || (go_hold && is_slow_op(hold_op));
            if (accept && !go_new) begin
                hold_valid <= 1'b1;
            end else if (go_hold) begin
                hold_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (go_new) begin
            iss_op  <= in_op;
            iss_a   <= new_a.val;
            iss_b   <= new_b.val;
            iss_tag <= alloc_tag;
        end else if (go_hold) begin
            iss_op  <= hold_op;
            iss_a   <= hold_a_now.val;
            iss_b   <= hold_b_now.val;
            iss_tag <= hold_tag;
        end
        if (accept) begin
            hold_op    <= in_op;
            hold_tag   <= alloc_tag;
            hold_a_tag <= ren_rs1_tag;
            hold_b_tag <= ren_rs2_tag;
            hold_a     <= new_a;
            hold_b     <= new_b;
        end else if (hold_valid) begin
            hold_a <= hold_a_now;
            hold_b <= hold_b_now;
        end
    end

    // both units see the same payload, valid picks the target
    assign fast_iss.valid = iss_fast_q;
    assign fast_iss.op    = iss_op;
    assign fast_iss.a     = iss_a;
    assign fast_iss.b     = iss_b;
    assign fast_iss.tag   = iss_tag;
    assign slow_iss.valid = iss_slow_q;
    assign slow_iss.op    = iss_op;
    assign slow_iss.a     = iss_a;
    assign slow_iss.b     = iss_b;
    assign slow_iss.tag   = iss_tag;

endmodule

`default_nettype wire

//--- reorder_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module reorder_buffer
    import ooo_pkg::*;
#(
    parameter int DEPTH = 8
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     alloc,
    input  reg_idx_t alloc_rd,
    output tag_t     alloc_tag,
    output logic     full,
    input  tag_t     lookup1_tag,
    input  tag_t     lookup2_tag,
    output logic     lookup1_ready,
    output data_t    lookup1_value,
    output logic     lookup2_ready,
    output data_t    lookup2_value,
    result_if.dst    fast_res,
    result_if.dst    slow_res,
    commit_if.src    cmt
);

    localparam int PTR_W = $clog2(DEPTH);

    typedef logic [PTR_W-1:0] ptr_t;

    ptr_t             head;
    ptr_t             tail;
    ptr_t             next_tail;
    logic             empty;
    logic             do_alloc;
    logic             do_commit;
    logic [DEPTH-1:0] rdy;
    reg_idx_t         rd_q  [DEPTH];
    data_t            val_q [DEPTH];

    function automatic ptr_t bump(input ptr_t p);
        return (p == ptr_t'(DEPTH - 1)) ? '0 : p + ptr_t'(1);
    endfunction

    function automatic ptr_t tag_idx(input tag_t t);
        return ptr_t'(t - tag_t'(1));
    endfunction

    // one slot stays unused to tell full from empty
    assign next_tail = bump(tail);
    assign empty     = (head == tail);
    assign full      = (next_tail == head);
    assign alloc_tag = tag_t'(tail) + tag_t'(1);
    assign do_alloc  = alloc && !full;
    assign do_commit = !empty && rdy[head];

    // ready survives commit so dispatch can still read it before write-back
    assign lookup1_ready = (lookup1_tag != NO_TAG) && rdy[tag_idx(lookup1_tag)];
    assign lookup1_value = val_q[tag_idx(lookup1_tag)];
    assign lookup2_ready = (lookup2_tag != NO_TAG) && rdy[tag_idx(lookup2_tag)];
    assign lookup2_value = val_q[tag_idx(lookup2_tag)];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head      <= '0;
            tail      <= '0;
            rdy       <= '0;
            cmt.valid <= 1'b0;
        end else begin
            cmt.valid <= do_commit;
            if (do_commit) begin
                head <= bump(head);
            end
            if (do_alloc) begin
                tail      <= next_tail;
                rdy[tail] <= 1'b0;
            end
            if (fast_res.valid) begin
                rdy[tag_idx(fast_res.tag)] <= 1'b1;
            end
            if (slow_res.valid) begin
                rdy[tag_idx(slow_res.tag)] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_commit) begin
            cmt.rd    <= rd_q[head];
            cmt.tag   <= tag_t'(head) + tag_t'(1);
            cmt.value <= val_q[head];
        end
        if (do_alloc) begin
            rd_q[tail] <= alloc_rd;
        end
        if (fast_res.valid) begin
            val_q[tag_idx(fast_res.tag)] <= fast_res.result;
        end
        if (slow_res.valid) begin
            val_q[tag_idx(slow_res.tag)] <= slow_res.result;
        end
    end

endmodule

`default_nettype wire

//--- exec_unit.sv
`timescale 1ns/1ns
`default_nettype none

module exec_unit
    import ooo_pkg::*;
#(
    parameter int LATENCY = 1
) (
    input  logic  clk,
    input  logic  rst_n,
    issue_if.dst  iss,
    result_if.src res
);

    logic [LATENCY-1:0] vld_q;
    tag_t               tag_q [LATENCY];
    data_t              res_q [LATENCY];
    data_t              alu_out;

    always_comb begin
        case (iss.op)
            OP_ADD:  alu_out = iss.a + iss.b;
            OP_SUB:  alu_out = iss.a - iss.b;
            OP_AND:  alu_out = iss.a & iss.b;
            OP_XOR:  alu_out = iss.a ^ iss.b;
            // low half of the product
            OP_MUL:  alu_out = iss.a * iss.b;
            default: alu_out = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= iss.valid;
            for (int i = 1; i < LATENCY; i++) begin
                vld_q[i] <= vld_q[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        tag_q[0] <= iss.tag;
        res_q[0] <= alu_out;
        for (int i = 1; i < LATENCY; i++) begin
            tag_q[i] <= tag_q[i-1];
            res_q[i] <= res_q[i-1];
        end
    end

    assign res.valid  = vld_q[LATENCY-1];
    assign res.tag    = tag_q[LATENCY-1];
    assign res.result = res_q[LATENCY-1];

endmodule

`default_nettype wire

//--- rename_table.sv
`timescale 1ns/1ns
`default_nettype none

module rename_table
    import ooo_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    output data_t    rs1_value,
    output data_t    rs2_value,
    output tag_t     rs1_tag,
    output tag_t     rs2_tag,
    input  logic     alloc,
    input  reg_idx_t alloc_rd,
    input  tag_t     alloc_tag,
    commit_if.dst    cmt
);

    data_t regs [NUM_REGS];
    tag_t  tags [NUM_REGS];

    // r0 is never written and never renamed, so it reads as zero
    assign rs1_value = regs[rs1];
    assign rs2_value = regs[rs2];
    assign rs1_tag   = tags[rs1];
    assign rs2_tag   = tags[rs2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
                tags[i] <= NO_TAG;
            end
        end else begin
            if (cmt.valid && cmt.rd != '0) begin
                regs[cmt.rd] <= cmt.value;
                // a younger producer keeps its claim
                if (tags[cmt.rd] == cmt.tag) begin
                    tags[cmt.rd] <= NO_TAG;
                end
            end
            // new allocation overrides the clear above
            if (alloc && alloc_rd != '0) begin
                tags[alloc_rd] <= alloc_tag;
            end
        end
    end

endmodule

`default_nettype wire

//--- ooo_ifs.sv
`timescale 1ns/1ns
`default_nettype none

// dispatch to one execution unit
interface issue_if
    import ooo_pkg::*;
();
    logic  valid;
    op_t   op;
    data_t a;
    data_t b;
    tag_t  tag;

    modport src (output valid, op, a, b, tag);
    modport dst (input valid, op, a, b, tag);
endinterface

// execution unit result broadcast
interface result_if
    import ooo_pkg::*;
();
    logic  valid;
    tag_t  tag;
    data_t result;

    modport src (output valid, tag, result);
    modport dst (input valid, tag, result);
    // dispatch watches the bus for waiting operands
    modport snoop (input valid, tag, result);
endinterface

// in-order retirement to the register file
interface commit_if
    import ooo_pkg::*;
();
    logic     valid;
    reg_idx_t rd;
    tag_t     tag;
    data_t    value;

    modport src (output valid, rd, tag, value);
    modport dst (input valid, rd, tag, value);
endinterface

`default_nettype wire

//--- ooo_pkg.sv
`default_nettype none

package ooo_pkg;

    localparam int DATA_W   = 32;
    localparam int REG_W    = 4;
    localparam int TAG_W    = 4;
    localparam int NUM_REGS = 1 << REG_W;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [REG_W-1:0]  reg_idx_t;

    // entry index plus one, zero when the register file holds the value
    typedef logic [TAG_W-1:0]  tag_t;

    localparam tag_t NO_TAG = '0;

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_XOR = 3'd3,
        OP_MUL = 3'd4
    } op_t;

    // multiplier sits in the long-latency unit
    function automatic logic is_slow_op(input op_t op);
        return op == OP_MUL;
    endfunction

endpackage

`default_nettype wire
